// File: vlog.f
source/fmul_pkg.sv
source/fmul_flow_stage.sv
source/fmul_classify.sv
source/fmul_exponent.sv
source/fmul_mantissa.sv
source/fmul_round.sv
source/fmul_top.sv
bench/fmul_props.sv
bench/fmul_tb.sv

// File: bench/fmul_tb.sv
`timescale 1ns/1ns

module fmul_tb
    import fmul_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int N_BASIC      = 200;
    localparam int N_MODES      = 300;
    localparam int N_SPECIAL    = 150;
    localparam int N_EXTREME    = 150;
    localparam int N_STALL      = 300;
    localparam int WATCHDOG_CYCLES = 40 + RESET_CYCLES + (4 + 8 * N_BASIC) + (4 + 8 * N_MODES) +
                                     (4 + 8 * N_SPECIAL) + (4 + 8 * N_EXTREME) +
                                     (4 + 8 * N_STALL);

    localparam int KIND_BASIC   = 0;
    localparam int KIND_MODES   = 1;
    localparam int KIND_SPECIAL = 2;
    localparam int KIND_EXTREME = 3;

    logic   clk, rst_n, in_valid, in_ready, out_ready, out_valid;
    float_t a, b, result;
    rm_t    rm;
    tag_t   tag, out_tag;
    flags_t flags;

    float_t q_result[$];
    flags_t q_flags[$];
    tag_t   q_tag[$];
    int     q_cycle[$];

    float_t model_result;
    flags_t model_flags;
    int     cycle, accepted, errors, ops_sent, results_seen, tests_run;
    bit     check_latency, stall_mode;

    fmul_top fmul_top_inst (
        .clk, .rst_n, .in_valid, .in_ready, .a, .b, .rm, .tag,
        .out_ready, .out_valid, .result, .flags, .out_tag
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic void model_mul(input float_t x, input float_t y, input rm_t mode,
                                      output float_t res, output flags_t flg);
        int              ex, ey, e;
        bit              sgn, x_zero, y_zero, x_inf, y_inf, x_nan, y_nan, x_snan, y_snan;
        bit              inf_zero, up, away;
        longint unsigned prod, frac, rem, half;
        ex       = x[30:23];
        ey       = y[30:23];
        sgn      = x[31] ^ y[31];
        x_zero   = (ex == 0);   // Subnormals too.
        y_zero   = (ey == 0);
        x_inf    = (ex == 255) && (x[22:0] == 0);
        y_inf    = (ey == 255) && (y[22:0] == 0);
        x_nan    = (ex == 255) && (x[22:0] != 0);
        y_nan    = (ey == 255) && (y[22:0] != 0);
        x_snan   = x_nan && !x[22];
        y_snan   = y_nan && !y[22];
        inf_zero = (x_inf || y_inf) && (x_zero || y_zero);
        flg      = '0;
        if (x_nan || y_nan || inf_zero) begin
            res          = CANON_NAN;
            flg[FLAG_NV] = x_snan || y_snan || inf_zero;
        end else if (x_inf || y_inf) begin
            res = {sgn, 8'hff, 23'h0};
        end else if (x_zero || y_zero) begin
            res = {sgn, 31'h0};
        end else begin
            prod = ({41'h1, x[22:0]}) * ({41'h1, y[22:0]});
            e    = ex + ey - EXP_BIAS;
            if (prod >= (64'd1 << 47)) begin
                e++;
                half = 64'd1 << 23;
                rem  = prod % (64'd1 << 24);
                frac = (prod >> 24) % (64'd1 << 23);
            end else begin
                half = 64'd1 << 22;
                rem  = prod % (64'd1 << 23);
                frac = (prod >> 23) % (64'd1 << 23);
            end
            case (mode)
                RM_RNE:  up = (rem > half) || (rem == half && frac[0]);
                RM_RMM:  up = (rem >= half);
                RM_RUP:  up = (rem != 0) && !sgn;
                RM_RDN:  up = (rem != 0) && sgn;
                default: up = 1'b0;
            endcase
            frac = frac + up;
            if (frac == (64'd1 << 23)) begin
                frac = 0;
                e++;
            end
            away = (mode == RM_RNE) || (mode == RM_RMM) ||
                   (mode == RM_RUP && !sgn) || (mode == RM_RDN && sgn);
            if (e > EXP_MAX) begin
                res          = away ? {sgn, 8'hff, 23'h0} : {sgn, 8'hfe, 23'h7fffff};
                flg[FLAG_OF] = 1'b1;
                flg[FLAG_NX] = 1'b1;
            end else if (e < 1) begin
                res          = {sgn, 31'h0};
                flg[FLAG_UF] = 1'b1;
                flg[FLAG_NX] = 1'b1;
            end else begin
                res          = {sgn, 8'(e), 23'(frac)};
                flg[FLAG_NX] = (rem != 0);
            end
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Scoreboard. Acceptance and delivery are both seen at the rising edge.
    always @(posedge clk) begin
        cycle++;
        if (rst_n && in_valid && in_ready) begin
            model_mul(a, b, rm, model_result, model_flags);
            q_result.push_back(model_result);
            q_flags.push_back(model_flags);
            q_tag.push_back(tag);
            q_cycle.push_back(cycle);
        end
        if (rst_n && out_valid && out_ready) begin
            if (q_result.size() == 0) begin
                $display("ERROR at %0t ns: a result came out with no operation pending", $time);
                errors++;
            end else begin
                compare("result", q_result.pop_front(), result);
                compare("flags", q_flags.pop_front(), flags);
                compare("out_tag", q_tag.pop_front(), out_tag);
                accepted = q_cycle.pop_front();
                if (check_latency)
                    compare("latency", 4, cycle - accepted);
                results_seen++;
            end
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = stall_mode ? 1'($urandom % 2) : 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: the pipeline stopped delivering results in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic float_t rand_normal();
        return {1'($urandom % 2), 8'(64 + $urandom % 128), 23'($urandom)};
    endfunction

    function automatic float_t rand_special();
        logic        s;
        logic [22:0] f;
        s = 1'($urandom % 2);
        f = 23'($urandom);
        case ($urandom % 5)
            0:       return {s, 8'h00, 23'h0};
            1:       return {s, 8'hff, 23'h0};
            2:       return {s, 8'hff, 1'b1, f[21:0]};
            3:       return {s, 8'hff, 1'b0, f[21:1], 1'b1};   // Signalling.
            default: return {s, 8'h00, f | 23'h1};            // Subnormal.
        endcase
    endfunction

    // Exponent sum lands a few steps around 0 or 255.
    task automatic rand_extreme(output float_t x, output float_t y);
        int ex, ey, delta;
        delta = int'($urandom % 6) - 3;
        if ($urandom % 2) begin
            ex = 1 + int'($urandom % 60);
            ey = EXP_BIAS - ex + delta;
        end else begin
            ex = 190 + int'($urandom % 65);
            ey = EXP_MAX + 1 + EXP_BIAS - ex + delta;
        end
        x = {1'($urandom % 2), 8'(ex), 23'($urandom)};
        y = {1'($urandom % 2), 8'(ey), 23'($urandom)};
    endtask

    task automatic make_operands(input int kind, output float_t x, output float_t y,
                                 output rm_t mode);
        mode = rm_t'($urandom % 5);
        x    = rand_normal();
        y    = rand_normal();
        if (kind == KIND_BASIC) begin
            mode = RM_RNE;
        end else if (kind == KIND_SPECIAL) begin
            x = rand_special();
            if ($urandom % 2)
                y = rand_special();
            if ($urandom % 2)
                {x, y} = {y, x};
        end else if (kind == KIND_EXTREME) begin
            rand_extreme(x, y);
        end
    endtask

    task automatic send_op(input float_t x, input float_t y, input rm_t mode);
        a        = x;
        b        = y;
        rm       = mode;
        tag      = tag_t'(ops_sent);
        in_valid = 1'b1;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        #1;
        in_valid = 1'b0;
        ops_sent++;
    endtask

    task automatic drain();
        while (q_result.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input string name, input int kind, input int n_ops,
                            input bit gaps);
        float_t x, y;
        rm_t    mode;
        int     err0;
        err0 = errors;
        for (int i = 0; i < n_ops; i++) begin
            make_operands(kind, x, y, mode);
            if (gaps && ($urandom % 4 == 0))
                repeat (1 + $urandom % 3) @(posedge clk);
            if (gaps)
                #1;
            send_op(x, y, mode);
        end
        drain();
        tests_run++;
        $display("%s: %0d operations, %0d errors", name, n_ops, errors - err0);
    endtask

    initial begin
        int err0;
        rst_n    = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        rm       = RM_RNE;
        tag      = '0;
        void'($urandom(32'h084bf5c7));
        #1;
        rst_n = 1'b0;   // Falling edge clears every stage.

        err0 = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare("out_valid", 1'b0, out_valid);
            compare("in_ready", 1'b1, in_ready);
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            compare("out_valid", 1'b0, out_valid);
            compare("in_ready", 1'b1, in_ready);
        end
        @(posedge clk);
        #1;
        tests_run++;
        $display("reset: %0d errors", errors - err0);

        check_latency = 1'b1;
        run_test("normal operands, RNE", KIND_BASIC, N_BASIC, 1'b0);
        check_latency = 1'b0;
        run_test("normal operands, all modes", KIND_MODES, N_MODES, 1'b0);
        run_test("special operands", KIND_SPECIAL, N_SPECIAL, 1'b0);
        run_test("exponent extremes", KIND_EXTREME, N_EXTREME, 1'b0);
        stall_mode = 1'b1;
        run_test("back-pressure and gaps", KIND_MODES, N_STALL, 1'b1);
        stall_mode = 1'b0;

        if (results_seen != ops_sent) begin
            $display("ERROR: %0d operations sent but %0d results received",
                     ops_sent, results_seen);
            errors++;
        end
        $display("Tests: %0d, operations: %0d, results: %0d, errors: %0d",
                 tests_run, ops_sent, results_seen, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/fmul_props.sv
`timescale 1ns/1ns

module fmul_props
    import fmul_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   in_ready,
    input logic   out_ready,
    input logic   out_valid,
    input float_t result,
    input flags_t flags,
    input tag_t   out_tag
);

    // Nothing leaves the pipeline while in reset.
    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while rst_n is low");

    // A stalled result holds.
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags) &&
                                    $stable(out_tag))
        else $error("output stream changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n) out_ready |-> in_ready)
        else $error("in_ready low with out_ready high");   // Full flow never stalls.

endmodule

bind fmul_top fmul_props props_inst (
    .clk(clk), .rst_n(rst_n), .in_ready(in_ready), .out_ready(out_ready),
    .out_valid(out_valid), .result(result), .flags(flags), .out_tag(out_tag)
);

// File: source/fmul_top.sv
`timescale 1ns/1ns

module fmul_top
    import fmul_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  float_t a,
    input  float_t b,
    input  rm_t    rm,
    input  tag_t   tag,
    input  logic   out_ready,
    output logic   out_valid,
    output float_t result,
    output flags_t flags,
    output tag_t   out_tag
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Inter-stage streams.
    // ~~~~~~~~~~~~~~~~~~~~
    logic       c_valid, c_ready, c_sign_a, c_sign_b;
    logic [7:0] c_exp_a, c_exp_b;
    sig_t       c_sig_a, c_sig_b;
    class_t     c_class_a, c_class_b;
    rm_t        c_rm, e_rm, m_rm;
    tag_t       c_tag, e_tag, m_tag;

    logic       e_valid, e_ready, e_sign, e_special, e_nv;
    exp_t       e_exp_sum, m_exp_sum;
    sig_t       e_sig_a, e_sig_b;
    float_t     e_special_result, m_special_result;

    logic       m_valid, m_ready, m_sign, m_special, m_nv;
    prod_t      m_product;

    fmul_classify classify_inst (
        .clk, .rst_n, .in_valid, .in_ready, .a, .b, .rm, .tag,
        .out_ready(c_ready), .out_valid(c_valid),
        .sign_a(c_sign_a), .sign_b(c_sign_b), .exp_a(c_exp_a), .exp_b(c_exp_b),
        .sig_a(c_sig_a), .sig_b(c_sig_b), .class_a(c_class_a), .class_b(c_class_b),
        .out_rm(c_rm), .out_tag(c_tag)
    );

    fmul_exponent exponent_inst (
        .clk, .rst_n, .in_valid(c_valid), .in_ready(c_ready),
        .sign_a(c_sign_a), .sign_b(c_sign_b), .exp_a(c_exp_a), .exp_b(c_exp_b),
        .sig_a(c_sig_a), .sig_b(c_sig_b), .class_a(c_class_a), .class_b(c_class_b),
        .rm(c_rm), .tag(c_tag),
        .out_ready(e_ready), .out_valid(e_valid),
        .sign(e_sign), .exp_sum(e_exp_sum), .out_sig_a(e_sig_a), .out_sig_b(e_sig_b),
        .special(e_special), .special_result(e_special_result), .special_nv(e_nv),
        .out_rm(e_rm), .out_tag(e_tag)
    );

    fmul_mantissa mantissa_inst (
        .clk, .rst_n, .in_valid(e_valid), .in_ready(e_ready),
        .sign(e_sign), .exp_sum(e_exp_sum), .sig_a(e_sig_a), .sig_b(e_sig_b),
        .special(e_special), .special_result(e_special_result), .special_nv(e_nv),
        .rm(e_rm), .tag(e_tag),
        .out_ready(m_ready), .out_valid(m_valid), .product(m_product),
        .out_sign(m_sign), .out_exp_sum(m_exp_sum), .out_special(m_special),
        .out_special_result(m_special_result), .out_special_nv(m_nv),
        .out_rm(m_rm), .out_tag(m_tag)
    );

    fmul_round round_inst (
        .clk, .rst_n, .in_valid(m_valid), .in_ready(m_ready),
        .product(m_product), .sign(m_sign), .exp_sum(m_exp_sum),
        .special(m_special), .special_result(m_special_result), .special_nv(m_nv),
        .rm(m_rm), .tag(m_tag),
        .out_ready, .out_valid, .result, .flags, .out_tag
    );

endmodule

// File: source/fmul_round.sv
`timescale 1ns/1ns

module fmul_round
    import fmul_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  prod_t  product,
    input  logic   sign,
    input  exp_t   exp_sum,
    input  logic   special,
    input  float_t special_result,
    input  logic   special_nv,
    input  rm_t    rm,
    input  tag_t   tag,
    input  logic   out_ready,
    output logic   out_valid,
    output float_t result,
    output flags_t flags,
    output tag_t   out_tag
);

    logic        top_bit, guard, sticky, round_up, to_inf;
    logic [22:0] frac;
    logic [23:0] frac_r;
    exp_t        exp_norm, exp_final;
    float_t      next_result;
    flags_t      next_flags;
    logic [40:0] stage_d;
    logic [40:0] stage_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Normalize to 1.f with guard and sticky.
    // ~~~~~~~~~~~~~~~~~~~~
    assign top_bit  = product[47];
    assign frac     = top_bit ? product[46:24] : product[45:23];
    assign guard    = top_bit ? product[23] : product[22];
    assign sticky   = top_bit ? |product[22:0] : |product[21:0];
    assign exp_norm = exp_sum + {9'b0, top_bit};

    always_comb begin
        round_up = 1'b0;
        case (rm)
            RM_RNE: round_up = guard & (sticky | frac[0]);
            RM_RMM: round_up = guard;
            RM_RUP: round_up = (guard | sticky) & !sign;
            RM_RDN: round_up = (guard | sticky) & sign;
            RM_RTZ: round_up = 1'b0;
            default: round_up = 1'b0;
        endcase
    end

    assign frac_r    = {1'b0, frac} + {23'b0, round_up};
    assign exp_final = exp_norm + {9'b0, frac_r[23]};   // Carry gives 1.0, fraction already zero.
    assign to_inf    = (rm == RM_RNE) || (rm == RM_RMM) ||
                       (rm == RM_RUP && !sign) || (rm == RM_RDN && sign);

    always_comb begin
        next_flags = '0;
        if (special) begin
            next_result          = special_result;
            next_flags[FLAG_NV]  = special_nv;
        end else if (exp_final > EXP_MAX) begin
            next_result          = to_inf ? {sign, 8'hff, 23'h0} : {sign, 8'hfe, 23'h7fffff};
            next_flags[FLAG_OF]  = 1'b1;
            next_flags[FLAG_NX]  = 1'b1;
        end else if (exp_final < 1) begin
            next_result          = {sign, 31'h0};   // Flush to zero.
            next_flags[FLAG_UF]  = 1'b1;
            next_flags[FLAG_NX]  = 1'b1;
        end else begin
            next_result          = {sign, exp_final[7:0], frac_r[22:0]};
            next_flags[FLAG_NX]  = guard | sticky;
        end
    end

    assign stage_d = {next_result, next_flags, tag};

    fmul_flow_stage #(.WIDTH($bits(stage_d))) stage_inst (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_data(stage_d),
        .out_ready, .out_valid, .out_data(stage_q)
    );

    assign {result, flags, out_tag} = stage_q;

endmodule

// File: source/fmul_mantissa.sv
`timescale 1ns/1ns

module fmul_mantissa
    import fmul_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  logic   sign,
    input  exp_t   exp_sum,
    input  sig_t   sig_a,
    input  sig_t   sig_b,
    input  logic   special,
    input  float_t special_result,
    input  logic   special_nv,
    input  rm_t    rm,
    input  tag_t   tag,
    input  logic   out_ready,
    output logic   out_valid,
    output prod_t  product,
    output logic   out_sign,
    output exp_t   out_exp_sum,
    output logic   out_special,
    output float_t out_special_result,
    output logic   out_special_nv,
    output rm_t    out_rm,
    output tag_t   out_tag
);

    prod_t next_product;
    logic [100:0] stage_d;
    logic [100:0] stage_q;

    assign next_product = prod_t'(sig_a) * prod_t'(sig_b);   // Full width, no truncation.

    assign stage_d = {next_product, sign, exp_sum, special,
                      special_result, special_nv, rm, tag};

    fmul_flow_stage #(.WIDTH($bits(stage_d))) stage_inst (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_data(stage_d),
        .out_ready, .out_valid, .out_data(stage_q)
    );

    assign {product, out_sign, out_exp_sum, out_special,
            out_special_result, out_special_nv, out_rm, out_tag} = stage_q;

endmodule

// File: source/fmul_exponent.sv
`timescale 1ns/1ns

module fmul_exponent
    import fmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       sign_a,
    input  logic       sign_b,
    input  logic [7:0] exp_a,
    input  logic [7:0] exp_b,
    input  sig_t       sig_a,
    input  sig_t       sig_b,
    input  class_t     class_a,
    input  class_t     class_b,
    input  rm_t        rm,
    input  tag_t       tag,
    input  logic       out_ready,
    output logic       out_valid,
    output logic       sign,
    output exp_t       exp_sum,
    output sig_t       out_sig_a,
    output sig_t       out_sig_b,
    output logic       special,
    output float_t     special_result,
    output logic       special_nv,
    output rm_t        out_rm,
    output tag_t       out_tag
);

    logic   next_sign, next_special, next_nv;
    exp_t   next_exp_sum;
    float_t next_result;
    logic   any_nan, any_snan, any_inf, any_zero, inf_zero;
    logic [100:0] stage_d;
    logic [100:0] stage_q;

    assign next_sign    = sign_a ^ sign_b;
    assign next_exp_sum = exp_t'({2'b00, exp_a}) + exp_t'({2'b00, exp_b}) - exp_t'(EXP_BIAS);

    assign any_snan = class_a[CLASS_SNAN] | class_b[CLASS_SNAN];
    assign any_nan  = any_snan | class_a[CLASS_QNAN] | class_b[CLASS_QNAN];
    assign any_inf  = class_a[CLASS_INF] | class_b[CLASS_INF];
    assign any_zero = class_a[CLASS_ZERO] | class_b[CLASS_ZERO];
    assign inf_zero = any_inf & any_zero;

    // ~~~~~~~~~~~~~~~~~~~~
    // Special operand priority: NaN, then infinity, then zero.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_special = 1'b1;
        next_nv      = 1'b0;
        if (any_nan || inf_zero) begin
            next_result = CANON_NAN;
            next_nv     = any_snan | inf_zero;
        end else if (any_inf) begin
            next_result = {next_sign, 8'hff, 23'h0};
        end else if (any_zero) begin
            next_result = {next_sign, 31'h0};
        end else begin
            next_special = 1'b0;
            next_result  = '0;
        end
    end

    assign stage_d = {next_sign, next_exp_sum, sig_a, sig_b,
                      next_special, next_result, next_nv, rm, tag};

    fmul_flow_stage #(.WIDTH($bits(stage_d))) stage_inst (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_data(stage_d),
        .out_ready, .out_valid, .out_data(stage_q)
    );

    assign {sign, exp_sum, out_sig_a, out_sig_b,
            special, special_result, special_nv, out_rm, out_tag} = stage_q;

endmodule

// File: source/fmul_classify.sv
`timescale 1ns/1ns

module fmul_classify
    import fmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  float_t     a,
    input  float_t     b,
    input  rm_t        rm,
    input  tag_t       tag,
    input  logic       out_ready,
    output logic       out_valid,
    output logic       sign_a,
    output logic       sign_b,
    output logic [7:0] exp_a,
    output logic [7:0] exp_b,
    output sig_t       sig_a,
    output sig_t       sig_b,
    output class_t     class_a,
    output class_t     class_b,
    output rm_t        out_rm,
    output tag_t       out_tag
);

    logic [81:0] stage_d;
    logic [81:0] stage_q;

    function automatic class_t op_class(float_t f);
        class_t c;
        c = '0;
        if (f[30:23] == 8'h00) begin
            c[CLASS_ZERO] = 1'b1;   // Subnormals count as zero.
        end else if (f[30:23] == 8'hff) begin
            if (f[22:0] == '0)
                c[CLASS_INF] = 1'b1;
            else if (f[22])
                c[CLASS_QNAN] = 1'b1;
            else
                c[CLASS_SNAN] = 1'b1;
        end
        return c;
    endfunction

    function automatic sig_t op_sig(float_t f);
        return (f[30:23] == 8'h00) ? sig_t'(0) : {1'b1, f[22:0]};
    endfunction

    assign stage_d = {a[31], b[31], a[30:23], b[30:23],
                      op_sig(a), op_sig(b), op_class(a), op_class(b), rm, tag};

    fmul_flow_stage #(.WIDTH($bits(stage_d))) stage_inst (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_data(stage_d),
        .out_ready, .out_valid, .out_data(stage_q)
    );

    assign {sign_a, sign_b, exp_a, exp_b, sig_a, sig_b,
            class_a, class_b, out_rm, out_tag} = stage_q;

endmodule

// File: source/fmul_flow_stage.sv
`timescale 1ns/1ns

module fmul_flow_stage #(
    parameter int WIDTH = 32
)(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    input  logic             out_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data
);

    logic load;

    // Empty entry, or the current one leaves this cycle.
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;   // Drained with nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// File: source/fmul_pkg.sv
package fmul_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Vector types.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0]        float_t;   // IEEE single precision word.
    typedef logic signed [9:0]  exp_t;     // Biased exponent sum with headroom.
    typedef logic [23:0]        sig_t;     // Significand with hidden bit.
    typedef logic [47:0]        prod_t;
    typedef logic [3:0]         class_t;   // One-hot, all zero for a normal operand.
    typedef logic [2:0]         rm_t;
    typedef logic [4:0]         tag_t;
    typedef logic [3:0]         flags_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Format constants.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int     EXP_BIAS  = 127;
    localparam int     EXP_MAX   = 254;
    localparam float_t CANON_NAN = 32'h7fc0_0000;

    // RISC-V rounding mode encoding.
    localparam rm_t RM_RNE = 3'b000;
    localparam rm_t RM_RTZ = 3'b001;
    localparam rm_t RM_RDN = 3'b010;
    localparam rm_t RM_RUP = 3'b011;
    localparam rm_t RM_RMM = 3'b100;   // Nearest, ties away from zero.

    // Bit positions in class_t.
    localparam int CLASS_ZERO = 0;
    localparam int CLASS_INF  = 1;
    localparam int CLASS_QNAN = 2;
    localparam int CLASS_SNAN = 3;

    // Bit positions in flags_t, same order as fflags.
    localparam int FLAG_NX = 0;
    localparam int FLAG_UF = 1;
    localparam int FLAG_OF = 2;
    localparam int FLAG_NV = 3;

endpackage
